//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

SIM = obj_dir/Vstream_mem_tb

test: $(SIM)
	./$(SIM)

$(SIM): project.f hw/*.sv testbench/*.sv
	verilator --binary --timing --assert -Wno-fatal -j 0 \
	  --top-module stream_mem_tb -f project.f

clean:
	rm -rf obj_dir

//--- hw/block_store.sv
`timescale 1ns/100ps

module block_store (
  input  logic         clk_i,
  input  logic         rst_i,
  mem_beat_if.consumer cmd,
  mem_beat_if.producer res
);

  logic [mem_stream_pkg::data_width-1:0]      mem_r [mem_stream_pkg::mem_words];
  logic [mem_stream_pkg::mem_index_width-1:0] word_idx;
  logic                                       is_write;
  logic                                       take;

  // One-entry result register
  logic                                       res_v_r;
  logic                                       res_last_r;
  mem_stream_pkg::mem_header_s                res_header_r;
  logic [mem_stream_pkg::paddr_width-1:0]     res_addr_r;
  logic [mem_stream_pkg::data_width-1:0]      res_data_r;

  assign word_idx = cmd.beat_addr[mem_stream_pkg::word_offset_width +:
                                  mem_stream_pkg::mem_index_width];

  assign is_write = (cmd.base_header.msg_type == mem_stream_pkg::e_mem_wr)
                  | (cmd.base_header.msg_type == mem_stream_pkg::e_mem_uc_wr);

  // A new beat fits when the register is empty or drains this cycle
  assign cmd.ready_and = ~res_v_r | res.ready_and;
  assign take          = cmd.v & cmd.ready_and;

  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      if (is_write)
      begin
        mem_r[word_idx] <= cmd.data;
      end
      res_data_r   <= mem_r[word_idx];
      res_header_r <= cmd.base_header;
      res_addr_r   <= cmd.beat_addr;
      res_last_r   <= cmd.last;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      res_v_r <= 1'b0;
    end
    else if (take)
    begin
      res_v_r <= 1'b1;
    end
    else if (res.ready_and)
    begin
      res_v_r <= 1'b0;
    end
  end

  assign res.base_header = res_header_r;
  assign res.beat_addr   = res_addr_r;
  assign res.data        = res_data_r;
  assign res.v           = res_v_r;
  assign res.last        = res_last_r;

  // Addresses above the array would alias onto lower words
  beat_addr_in_range: assert property (
    @(posedge clk_i) disable iff (rst_i)
    cmd.v |-> (cmd.beat_addr < (mem_stream_pkg::mem_words * (mem_stream_pkg::data_width / 8)))
  );

endmodule

//--- hw/mem_beat_if.sv
`timescale 1ns/100ps

interface mem_beat_if;

  mem_stream_pkg::mem_header_s                 base_header;
  logic [mem_stream_pkg::paddr_width-1:0]      beat_addr;
  logic [mem_stream_pkg::data_width-1:0]       data;
  logic                                        v;
  logic                                        last;
  logic                                        ready_and;

  modport producer (
    output base_header,
    output beat_addr,
    output data,
    output v,
    output last,
    input  ready_and
  );

  modport consumer (
    input  base_header,
    input  beat_addr,
    input  data,
    input  v,
    input  last,
    output ready_and
  );

endinterface

//--- hw/mem_stream_pkg.sv
package mem_stream_pkg;

  localparam int paddr_width       = 12;
  localparam int data_width        = 64;
  localparam int block_width       = 512;
  localparam int stream_words      = block_width / data_width;
  localparam int word_offset_width = 3;
  localparam int cnt_width         = $clog2(stream_words);
  localparam int mem_words         = 64;
  localparam int mem_index_width   = $clog2(mem_words);

  typedef enum logic [1:0] {
    e_mem_rd    = 2'd0,
    e_mem_wr    = 2'd1,
    e_mem_uc_rd = 2'd2,
    e_mem_uc_wr = 2'd3
  } msg_type_e;

  // Log2 of the message size in bytes
  typedef enum logic [2:0] {
    e_size_8  = 3'd3,
    e_size_16 = 3'd4,
    e_size_32 = 3'd5,
    e_size_64 = 3'd6
  } msg_size_e;

  typedef struct packed {
    msg_type_e              msg_type;
    msg_size_e              size;
    logic [paddr_width-1:0] addr;
  } mem_header_s;

  // One bit per message type, set where the type carries a data payload
  localparam logic [3:0] cmd_payload_mask  = (4'b1 << e_mem_wr) | (4'b1 << e_mem_uc_wr);
  localparam logic [3:0] resp_payload_mask = (4'b1 << e_mem_rd) | (4'b1 << e_mem_uc_rd);
  localparam logic [3:0] stream_mask       = 4'b1111;

  // Number of beats in a message minus one
  function automatic logic [cnt_width-1:0] beat_span(msg_size_e size);
    if (size <= word_offset_width)
      return '0;
    return cnt_width'((1 << (size - word_offset_width)) - 1);
  endfunction

  // Address of the beat at word counter cnt, wrapped inside the size-aligned region
  function automatic logic [paddr_width-1:0] wrap_addr(logic [paddr_width-1:0] addr,
                                                       msg_size_e size,
                                                       logic [cnt_width-1:0] cnt);
    logic [cnt_width-1:0]   mask;
    logic [paddr_width-1:0] result;
    mask   = beat_span(size);
    result = addr;
    result[word_offset_width +: cnt_width] =
      (addr[word_offset_width +: cnt_width] & ~mask) | (cnt & mask);
    return result;
  endfunction

endpackage

//--- hw/stream_mem_top.sv
`timescale 1ns/100ps

module stream_mem_top (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  mem_stream_pkg::mem_header_s           cmd_header_i,
  input  logic [mem_stream_pkg::data_width-1:0] cmd_data_i,
  input  logic                                  cmd_v_i,
  input  logic                                  cmd_last_i,
  output logic                                  cmd_ready_and_o,
  output mem_stream_pkg::mem_header_s           resp_header_o,
  output logic [mem_stream_pkg::data_width-1:0] resp_data_o,
  output logic                                  resp_v_o,
  output logic                                  resp_last_o,
  input  logic                                  resp_ready_and_i
);

  mem_beat_if cmd_beats ();
  mem_beat_if res_beats ();

  stream_pump_in #(
    .payload_mask_p (mem_stream_pkg::cmd_payload_mask),
    .stream_mask_p  (mem_stream_pkg::stream_mask)
  ) i_stream_pump_in (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .bus_header_i    (cmd_header_i),
    .bus_data_i      (cmd_data_i),
    .bus_v_i         (cmd_v_i),
    .bus_last_i      (cmd_last_i),
    .bus_ready_and_o (cmd_ready_and_o),
    .beats           (cmd_beats)
  );

  block_store i_block_store (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .cmd   (cmd_beats),
    .res   (res_beats)
  );

  stream_pump_out #(
    .payload_mask_p (mem_stream_pkg::resp_payload_mask),
    .stream_mask_p  (mem_stream_pkg::stream_mask)
  ) i_stream_pump_out (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .beats           (res_beats),
    .bus_header_o    (resp_header_o),
    .bus_data_o      (resp_data_o),
    .bus_v_o         (resp_v_o),
    .bus_last_o      (resp_last_o),
    .bus_ready_and_i (resp_ready_and_i)
  );

endmodule

//--- hw/stream_pump_in.sv
`timescale 1ns/100ps

module stream_pump_in #(
  parameter logic [3:0] payload_mask_p = 4'b0000,
  parameter logic [3:0] stream_mask_p  = 4'b0000
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  mem_stream_pkg::mem_header_s           bus_header_i,
  input  logic [mem_stream_pkg::data_width-1:0] bus_data_i,
  input  logic                                  bus_v_i,
  input  logic                                  bus_last_i,
  output logic                                  bus_ready_and_o,
  mem_beat_if.producer                          beats
);

  logic [mem_stream_pkg::cnt_width-1:0]   span;
  logic [mem_stream_pkg::cnt_width-1:0]   first_cnt;
  logic [mem_stream_pkg::cnt_width-1:0]   last_cnt;
  logic [mem_stream_pkg::cnt_width-1:0]   cur_cnt;
  logic [mem_stream_pkg::cnt_width-1:0]   cnt_r;
  logic [mem_stream_pkg::paddr_width-1:0] exp_addr;
  logic                                   streaming_r;
  logic                                   has_data;
  logic                                   is_stream;
  logic                                   is_last_cnt;
  logic                                   take;

  // The word counter starts at the critical word of the base address
  assign span      = mem_stream_pkg::beat_span(bus_header_i.size);
  assign first_cnt = bus_header_i.addr[mem_stream_pkg::word_offset_width +:
                                       mem_stream_pkg::cnt_width];
  assign last_cnt  = first_cnt + span;
  assign cur_cnt   = streaming_r ? cnt_r : first_cnt;

  assign has_data    = payload_mask_p[bus_header_i.msg_type];
  assign is_stream   = stream_mask_p[bus_header_i.msg_type] & (span != '0);
  assign is_last_cnt = ~is_stream | (cur_cnt == last_cnt);

  assign exp_addr = mem_stream_pkg::wrap_addr(bus_header_i.addr, bus_header_i.size, cur_cnt);

  assign beats.base_header = bus_header_i;
  assign beats.beat_addr   = exp_addr;
  assign beats.data        = bus_data_i;
  assign beats.v           = bus_v_i;
  assign beats.last        = is_last_cnt;

  // A read header is held on the bus until its last beat has been taken
  assign bus_ready_and_o = beats.ready_and & (has_data | is_last_cnt);

  assign take = beats.v & beats.ready_and;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      streaming_r <= 1'b0;
      cnt_r       <= '0;
    end
    else if (take)
    begin
      if (is_last_cnt)
      begin
        streaming_r <= 1'b0;
      end
      else
      begin
        streaming_r <= 1'b1;
        cnt_r       <= cur_cnt + 1'b1;
      end
    end
  end

  // The sender's last flag must land on the beat this pump counts as final
  bus_last_matches_count: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (bus_v_i && bus_ready_and_o) |-> (bus_last_i == is_last_cnt)
  );

endmodule

//--- hw/stream_pump_out.sv
`timescale 1ns/100ps

module stream_pump_out #(
  parameter logic [3:0] payload_mask_p = 4'b0000,
  parameter logic [3:0] stream_mask_p  = 4'b0000
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  mem_beat_if.consumer                          beats,
  output mem_stream_pkg::mem_header_s           bus_header_o,
  output logic [mem_stream_pkg::data_width-1:0] bus_data_o,
  output logic                                  bus_v_o,
  output logic                                  bus_last_o,
  input  logic                                  bus_ready_and_i
);

  logic [mem_stream_pkg::cnt_width-1:0]   span;
  logic [mem_stream_pkg::cnt_width-1:0]   first_cnt;
  logic [mem_stream_pkg::cnt_width-1:0]   last_cnt;
  logic [mem_stream_pkg::cnt_width-1:0]   cur_cnt;
  logic [mem_stream_pkg::cnt_width-1:0]   cnt_r;
  logic [mem_stream_pkg::paddr_width-1:0] exp_addr;
  logic                                   streaming_r;
  logic                                   has_data;
  logic                                   is_stream;
  logic                                   is_last_cnt;
  logic                                   take;

  assign span      = mem_stream_pkg::beat_span(beats.base_header.size);
  assign first_cnt = beats.base_header.addr[mem_stream_pkg::word_offset_width +:
                                            mem_stream_pkg::cnt_width];
  assign last_cnt  = first_cnt + span;
  assign cur_cnt   = streaming_r ? cnt_r : first_cnt;

  assign has_data    = payload_mask_p[beats.base_header.msg_type];
  assign is_stream   = stream_mask_p[beats.base_header.msg_type] & (span != '0);
  assign is_last_cnt = ~is_stream | (cur_cnt == last_cnt);

  assign exp_addr = mem_stream_pkg::wrap_addr(beats.base_header.addr,
                                              beats.base_header.size, cur_cnt);

  always_comb
  begin
    bus_header_o = beats.base_header;
    if (has_data | ~is_stream)
    begin
      // Every beat goes out with the address of its own word
      bus_header_o.addr = exp_addr;
      bus_v_o           = beats.v;
      beats.ready_and   = bus_ready_and_i;
    end
    else
    begin
      // Write acknowledgements fold into one response carrying the base header
      bus_v_o         = beats.v & is_last_cnt;
      beats.ready_and = is_last_cnt ? bus_ready_and_i : 1'b1;
    end
  end

  assign bus_data_o = beats.data;
  assign bus_last_o = bus_v_o & is_last_cnt;

  assign take = beats.v & beats.ready_and;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      streaming_r <= 1'b0;
      cnt_r       <= '0;
    end
    else if (take)
    begin
      if (is_last_cnt)
      begin
        streaming_r <= 1'b0;
      end
      else
      begin
        streaming_r <= 1'b1;
        cnt_r       <= cur_cnt + 1'b1;
      end
    end
  end

  // The input pump and this pump walk each message in the same word order
  beat_addr_in_step: assert property (
    @(posedge clk_i) disable iff (rst_i)
    beats.v |-> (beats.beat_addr == exp_addr)
  );

  // Last from the store marks the same beat that closes the message here
  beat_last_in_step: assert property (
    @(posedge clk_i) disable iff (rst_i)
    beats.v |-> (beats.last == is_last_cnt)
  );

endmodule

//--- project.f
hw/mem_stream_pkg.sv
hw/mem_beat_if.sv
hw/stream_pump_in.sv
hw/stream_pump_out.sv
hw/block_store.sv
hw/stream_mem_top.sv
testbench/stream_mem_tb.sv

//--- testbench/stream_mem_tb.sv
`timescale 1ns/100ps

module stream_mem_tb;

  typedef struct {
    string                                  name;
    mem_stream_pkg::msg_type_e              msg_type;
    logic [mem_stream_pkg::paddr_width-1:0] addr;
    mem_stream_pkg::msg_size_e              size;
  } cmd_row_s;

  typedef struct {
    string                       name;
    mem_stream_pkg::mem_header_s header;
    logic [63:0]                 data;
    logic                        check_data;
    logic                        last;
  } resp_exp_s;

  logic                        clk_i;
  logic                        rst_i;
  mem_stream_pkg::mem_header_s cmd_header_i;
  logic [63:0]                 cmd_data_i;
  logic                        cmd_v_i;
  logic                        cmd_last_i;
  logic                        cmd_ready_and_o;
  mem_stream_pkg::mem_header_s resp_header_o;
  logic [63:0]                 resp_data_o;
  logic                        resp_v_o;
  logic                        resp_last_o;
  logic                        resp_ready_and_i;

  cmd_row_s    cmd_table[$];
  resp_exp_s   exp_q[$];
  // Words are only read after the table has written them
  logic [63:0] ref_mem [mem_stream_pkg::mem_words];
  logic [15:0] stim_lfsr  = 16'd80;
  logic [15:0] ready_lfsr = 16'd80;
  int unsigned cycle_count = 0;
  int unsigned cycle_limit;

  stream_mem_top i_stream_mem_top (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .cmd_header_i     (cmd_header_i),
    .cmd_data_i       (cmd_data_i),
    .cmd_v_i          (cmd_v_i),
    .cmd_last_i       (cmd_last_i),
    .cmd_ready_and_o  (cmd_ready_and_o),
    .resp_header_o    (resp_header_o),
    .resp_data_o      (resp_data_o),
    .resp_v_o         (resp_v_o),
    .resp_last_o      (resp_last_o),
    .resp_ready_and_i (resp_ready_and_i)
  );

  // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  function automatic logic stim_bit();
    stim_lfsr = lfsr_step(stim_lfsr);
    return stim_lfsr[0];
  endfunction

  function automatic logic ready_bit();
    ready_lfsr = lfsr_step(ready_lfsr);
    return ready_lfsr[0];
  endfunction

  function automatic logic [63:0] random_word();
    logic [63:0] word;
    int          b;
    for (b = 0; b < 64; b++)
      word[b] = stim_bit();
    return word;
  endfunction

  function automatic int unsigned size_bytes(input mem_stream_pkg::msg_size_e size);
    return 32'd1 << size;
  endfunction

  // Beat k sits in the S-aligned region of A at offset (A + 8k) mod S
  function automatic logic [mem_stream_pkg::paddr_width-1:0] beat_address(
    input logic [mem_stream_pkg::paddr_width-1:0] addr,
    input mem_stream_pkg::msg_size_e              size,
    input int unsigned                            k
  );
    int unsigned s;
    int unsigned region;
    int unsigned offset;
    s      = size_bytes(size);
    region = int'(addr) & ~(s - 1);
    offset = (int'(addr) + 8 * k) % s;
    return mem_stream_pkg::paddr_width'(region + offset);
  endfunction

  function automatic int unsigned table_beats();
    int unsigned total;
    total = 0;
    foreach (cmd_table[i])
      total += size_bytes(cmd_table[i].size) / 8;
    return total;
  endfunction

  task automatic add_row(input string name, input mem_stream_pkg::msg_type_e msg_type,
                         input logic [11:0] addr, input mem_stream_pkg::msg_size_e size);
    cmd_row_s row;
    row.name     = name;
    row.msg_type = msg_type;
    row.addr     = addr;
    row.size     = size;
    cmd_table.push_back(row);
  endtask

  task automatic check_value(input string test_name, input string field,
                             input logic [63:0] expected, input logic [63:0] actual);
    if (actual !== expected)
    begin
      $display("error %s %s expected %h actual %h", test_name, field, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "Mismatch in %s", test_name);
    end
  endtask

  // Holds one bus beat, with an occasional valid gap, until the DUT takes it
  task automatic send_beat(input mem_stream_pkg::mem_header_s header,
                           input logic [63:0] data, input logic last,
                           output int unsigned held);
    cmd_header_i <= header;
    cmd_data_i   <= data;
    cmd_last_i   <= last;
    while (stim_bit() & stim_bit())
    begin
      cmd_v_i <= 1'b0;
      @(posedge clk_i);
    end
    cmd_v_i <= 1'b1;
    @(posedge clk_i);
    held = 1;
    while (!cmd_ready_and_o)
    begin
      @(posedge clk_i);
      held++;
    end
  endtask

  task automatic issue_command(input cmd_row_s row);
    mem_stream_pkg::mem_header_s header;
    resp_exp_s                   exp;
    logic [63:0]                 wdata [8];
    logic [11:0]                 addr;
    int unsigned                 beats;
    int unsigned                 k;
    int unsigned                 held;
    header.msg_type = row.msg_type;
    header.size     = row.size;
    header.addr     = row.addr;
    beats           = size_bytes(row.size) / 8;
    exp.name        = row.name;
    exp.header      = header;
    if (row.msg_type == mem_stream_pkg::e_mem_wr || row.msg_type == mem_stream_pkg::e_mem_uc_wr)
    begin
      for (k = 0; k < beats; k++)
      begin
        wdata[k]          = random_word();
        addr              = beat_address(row.addr, row.size, k);
        ref_mem[addr / 8] = wdata[k];
      end
      // All word acknowledgements fold into one beat addressed at the first word
      exp.header.addr = beat_address(row.addr, row.size, 0);
      exp.data        = '0;
      exp.check_data  = 1'b0;
      exp.last        = 1'b1;
      exp_q.push_back(exp);
      for (k = 0; k < beats; k++)
        send_beat(header, wdata[k], k == beats - 1, held);
    end
    else
    begin
      for (k = 0; k < beats; k++)
      begin
        addr            = beat_address(row.addr, row.size, k);
        exp.header.addr = addr;
        exp.data        = ref_mem[addr / 8];
        exp.check_data  = 1'b1;
        exp.last        = (k == beats - 1);
        exp_q.push_back(exp);
      end
      send_beat(header, '0, 1'b1, held);
      // The read header stays on the bus until every word beat has been taken
      check_value(row.name, "read_hold", 64'd1, 64'(held >= beats));
    end
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    if (rst_i)
      resp_ready_and_i <= 1'b0;
    else
      resp_ready_and_i <= ready_bit() | ready_bit();
  end

  always @(posedge clk_i)
  begin
    resp_exp_s exp;
    if (!rst_i && resp_v_o && resp_ready_and_i)
    begin
      if (exp_q.size() == 0)
      begin
        $display("A response beat came out while no response was expected");
        $display("TESTBENCH FAILED");
        $fatal(1, "Unexpected response beat");
      end
      else
      begin
        exp = exp_q.pop_front();
        check_value(exp.name, "msg_type", 64'(exp.header.msg_type), 64'(resp_header_o.msg_type));
        check_value(exp.name, "size", 64'(exp.header.size), 64'(resp_header_o.size));
        check_value(exp.name, "addr", 64'(exp.header.addr), 64'(resp_header_o.addr));
        check_value(exp.name, "last", 64'(exp.last), 64'(resp_last_o));
        if (exp.check_data)
          check_value(exp.name, "data", exp.data, resp_data_o);
      end
    end
  end

  always @(posedge clk_i)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit)
    begin
      $display("The run went past %0d cycles without finishing", cycle_limit);
      $display("TESTBENCH FAILED");
      $fatal(1, "Timeout");
    end
  end

  initial
  begin
    cmd_header_i     <= '0;
    cmd_data_i       <= '0;
    cmd_v_i          <= 1'b0;
    cmd_last_i       <= 1'b0;
    resp_ready_and_i <= 1'b0;
    rst_i            <= 1'b1;

    add_row("wr64_unaligned", mem_stream_pkg::e_mem_wr, 12'h058, mem_stream_pkg::e_size_64);
    add_row("rd64_unaligned", mem_stream_pkg::e_mem_rd, 12'h058, mem_stream_pkg::e_size_64);
    add_row("wr16_wrap", mem_stream_pkg::e_mem_wr, 12'h048, mem_stream_pkg::e_size_16);
    add_row("wr32_wrap", mem_stream_pkg::e_mem_wr, 12'h070, mem_stream_pkg::e_size_32);
    add_row("rd64_after_small", mem_stream_pkg::e_mem_rd, 12'h040, mem_stream_pkg::e_size_64);
    add_row("rd16_wrap", mem_stream_pkg::e_mem_rd, 12'h048, mem_stream_pkg::e_size_16);
    add_row("rd32_wrap", mem_stream_pkg::e_mem_rd, 12'h078, mem_stream_pkg::e_size_32);
    add_row("uc_wr8", mem_stream_pkg::e_mem_uc_wr, 12'h1a0, mem_stream_pkg::e_size_8);
    add_row("uc_rd8", mem_stream_pkg::e_mem_uc_rd, 12'h1a0, mem_stream_pkg::e_size_8);
    add_row("wr64_high", mem_stream_pkg::e_mem_wr, 12'h1c8, mem_stream_pkg::e_size_64);
    add_row("rd32_high", mem_stream_pkg::e_mem_rd, 12'h1e8, mem_stream_pkg::e_size_32);
    add_row("uc_rd8_high", mem_stream_pkg::e_mem_uc_rd, 12'h1f0, mem_stream_pkg::e_size_8);
    add_row("wr16_high", mem_stream_pkg::e_mem_wr, 12'h1d8, mem_stream_pkg::e_size_16);
    add_row("rd64_high", mem_stream_pkg::e_mem_rd, 12'h1f8, mem_stream_pkg::e_size_64);
    add_row("uc_wr8_low", mem_stream_pkg::e_mem_uc_wr, 12'h058, mem_stream_pkg::e_size_8);
    add_row("rd16_low", mem_stream_pkg::e_mem_rd, 12'h050, mem_stream_pkg::e_size_16);
    cycle_limit = 20 * table_beats() + 100;

    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;

    // Nothing has been sent yet, so no response may appear
    repeat (4)
    begin
      @(posedge clk_i);
      check_value("idle_after_reset", "resp_v", 64'd0, 64'(resp_v_o));
    end

    foreach (cmd_table[i])
      issue_command(cmd_table[i]);
    cmd_v_i    <= 1'b0;
    cmd_last_i <= 1'b0;

    while (exp_q.size() != 0)
      @(posedge clk_i);
    // A few quiet cycles catch any repeated beat
    repeat (5) @(posedge clk_i);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule
